/* Makefile */
# Verilator build for the memory stage testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_mem_subsys

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_mem_subsys \
		-o tb_mem_subsys
	./obj_dir/tb_mem_subsys

clean:
	rm -rf obj_dir

/* design/cache_req_if.sv */
`timescale 1ns/10ps

interface cache_req_if;
	import dcache_pkg::*;

	// request side, held until ready
	logic valid;
	logic rw;
	word_t addr;
	word_t wdata;

	// result side, ready lasts one cycle
	logic ready;
	word_t rdata;

	modport cpu (
		output valid,
		output rw,
		output addr,
		output wdata,
		input ready,
		input rdata
	);

	modport cache (
		input valid,
		input rw,
		input addr,
		input wdata,
		output ready,
		output rdata
	);

endinterface

/* design/dcache.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache (
	input logic clk_i,
	input logic rst_ni,
	cache_req_if.cache req,
	output logic bus_valid_o,
	output logic bus_rw_o,
	output dcache_pkg::word_t bus_addr_o,
	output dcache_pkg::line_t bus_wdata_o,
	input dcache_pkg::line_t bus_rdata_i,
	input logic bus_rvalid_i
);
	import dcache_pkg::*;

	dcache_state_e state_q;
	dcache_state_e state_d;
	word_t addr_q;
	logic [`DCACHE_INDEX_W-1:0] index;
	tag_t req_tag;
	tag_t tag_rd;
	logic valid_rd;
	logic dirty_rd;
	line_t line_rd;
	logic hit;
	logic line_we;
	logic word_we;

	// split the accepted address into tag and index
	assign index = addr_q[4 +: `DCACHE_INDEX_W];
	assign req_tag = addr_q[31 -: `DCACHE_TAG_W];
	assign hit = valid_rd && (tag_rd == req_tag);

	dcache_array i_array (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.index_i(index),
		.tag_o(tag_rd),
		.valid_o(valid_rd),
		.dirty_o(dirty_rd),
		.line_o(line_rd),
		.line_we_i(line_we),
		.line_i(bus_rdata_i),
		.tag_i(req_tag),
		.word_we_i(word_we),
		.word_sel_i(addr_q[3:2]),
		.word_i(req.wdata)
	);

	assign req.rdata = line_rd[{addr_q[3:2], 5'b0} +: 32];
	// victim line goes out as is
	assign bus_wdata_o = line_rd;
	assign line_we = (state_q == st_allocate) && bus_rvalid_i;

	always_comb begin
		state_d = state_q;
		req.ready = 1'b0;
		word_we = 1'b0;
		bus_valid_o = 1'b0;
		bus_rw_o = 1'b0;
		bus_addr_o = {req_tag, index, 4'b0};
		unique case (state_q)
			st_idle: begin
				if (req.valid) begin
					state_d = st_compare;
				end
			end
			st_compare: begin
				if (!req.valid) begin
					// request withdrawn by the pipeline
					state_d = st_idle;
				end else if (hit) begin
					req.ready = 1'b1;
					word_we = req.rw;
					state_d = st_idle;
				end else if (dirty_rd) begin
					state_d = st_write_back;
				end else begin
					state_d = st_allocate;
				end
			end
			st_write_back: begin
				bus_valid_o = 1'b1;
				bus_rw_o = 1'b1;
				bus_addr_o = {tag_rd, index, 4'b0};
				if (bus_rvalid_i) begin
					state_d = st_allocate;
				end
			end
			st_allocate: begin
				bus_valid_o = 1'b1;
				// refilled line is checked again in compare
				if (bus_rvalid_i) begin
					state_d = st_compare;
				end
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	// address stays fixed for the whole miss
	always_ff @(posedge clk_i) begin
		if (state_q == st_idle && req.valid) begin
			addr_q <= req.addr;
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

/* design/dcache_array.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_array (
	input logic clk_i,
	input logic rst_ni,
	input logic [`DCACHE_INDEX_W-1:0] index_i,
	output dcache_pkg::tag_t tag_o,
	output logic valid_o,
	output logic dirty_o,
	output dcache_pkg::line_t line_o,
	input logic line_we_i,
	input dcache_pkg::line_t line_i,
	input dcache_pkg::tag_t tag_i,
	input logic word_we_i,
	input logic [1:0] word_sel_i,
	input dcache_pkg::word_t word_i
);
	import dcache_pkg::*;

	tag_t tag_mem [`DCACHE_SETS];
	line_t data_mem [`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0] valid_q;
	logic [`DCACHE_SETS-1:0] dirty_q;

	// asynchronous read of the addressed set
	assign tag_o = tag_mem[index_i];
	assign line_o = data_mem[index_i];
	assign valid_o = valid_q[index_i];
	assign dirty_o = dirty_q[index_i];

	always_ff @(posedge clk_i) begin
		if (line_we_i) begin
			tag_mem[index_i] <= tag_i;
			data_mem[index_i] <= line_i;
		end else if (word_we_i) begin
			data_mem[index_i][{word_sel_i, 5'b0} +: 32] <= word_i;
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (line_we_i) begin
			// fresh line from memory is clean
			valid_q[index_i] <= 1'b1;
			dirty_q[index_i] <= 1'b0;
		end else if (word_we_i) begin
			dirty_q[index_i] <= 1'b1;
		end
	end

endmodule

/* design/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

	// data or address word
	typedef logic [31:0] word_t;

	// one cache line, word 0 in the low bits
	typedef logic [`DCACHE_LINE_W-1:0] line_t;

	// address bits above index and offset
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;

	// write-back source select
	typedef logic [1:0] wb_sel_t;

	// controller states
	typedef enum logic [1:0] {
		st_idle,
		st_compare,
		st_write_back,
		st_allocate
	} dcache_state_e;

endpackage

/* design/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// direct-mapped geometry, 16-byte lines
`define DCACHE_SETS 64
`define DCACHE_INDEX_W 6

// 32 address bits minus index and 4 offset bits
`define DCACHE_TAG_W 22

// four 32-bit words per line
`define DCACHE_LINE_W 128

// top nibble of a cached address
`define CACHED_NIBBLE 4'h0

`endif

/* design/mem_stage.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module mem_stage (
	input logic clk_i,
	input logic rst_ni,
	input logic enable_i,
	input logic flush_i,
	input logic icache_stall_i,
	input logic access_i,
	input logic mem_rw_i,
	input dcache_pkg::word_t alu_i,
	input dcache_pkg::word_t rs2_i,
	input dcache_pkg::word_t pc4_i,
	input dcache_pkg::word_t inst_i,
	input dcache_pkg::wb_sel_t wb_sel_i,
	input logic reg_wen_i,
	input logic [4:0] rd_i,
	input logic csr_we_i,
	input dcache_pkg::word_t csr_waddr_i,
	input dcache_pkg::word_t csr_rdata_i,
	cache_req_if.cpu req,
	input logic bus_valid_i,
	input logic bus_rw_i,
	input dcache_pkg::word_t bus_addr_i,
	input dcache_pkg::line_t bus_wdata_i,
	output dcache_pkg::line_t bus_rdata_o,
	output logic bus_rvalid_o,
	output dcache_pkg::word_t mem_addr_o,
	output dcache_pkg::line_t mem_wdata_o,
	output logic mem_we_o,
	output logic mem_cs_o,
	input dcache_pkg::line_t mem_rdata_i,
	input logic mem_rvalid_i,
	output logic stall_o,
	output dcache_pkg::word_t alu_o,
	output dcache_pkg::word_t mem_data_o,
	output dcache_pkg::word_t pc4_o,
	output dcache_pkg::word_t inst_o,
	output dcache_pkg::wb_sel_t wb_sel_o,
	output logic reg_wen_o,
	output logic [4:0] rd_o,
	output logic csr_we_o,
	output dcache_pkg::word_t csr_waddr_o,
	output dcache_pkg::word_t csr_rdata_o
);
	import dcache_pkg::*;

	logic cached;
	logic pending;
	logic unc_access;
	logic unc_cs;
	logic unc_rd_done;
	logic acc_done;
	logic advance;
	logic done_q;
	word_t data_q;
	word_t load_data;

	assign cached = alu_i[31 -: 4] == `CACHED_NIBBLE;
	// done_q keeps a finished access from repeating while the stage waits
	assign pending = access_i && !done_q;
	assign unc_access = pending && !cached;
	assign unc_cs = unc_access && !bus_valid_i;
	assign unc_rd_done = unc_cs && !mem_rw_i && mem_rvalid_i;
	assign acc_done = req.ready || (unc_cs && mem_rw_i) || unc_rd_done;

	assign req.valid = pending && cached && !icache_stall_i;
	assign req.rw = mem_rw_i;
	assign req.addr = alu_i;
	assign req.wdata = rs2_i;

	// cache line traffic has priority on the bus
	assign mem_cs_o = bus_valid_i || unc_cs;
	assign mem_we_o = bus_valid_i ? bus_rw_i : (unc_cs && mem_rw_i);
	assign mem_addr_o = bus_valid_i ? bus_addr_i : alu_i;
	assign mem_wdata_o = bus_valid_i ? bus_wdata_i : line_t'(rs2_i);
	assign bus_rdata_o = mem_rdata_i;
	assign bus_rvalid_o = mem_rvalid_i;

	assign stall_o = !icache_stall_i && ((req.valid && !req.ready) ||
		(unc_access && (bus_valid_i || (!mem_rw_i && !mem_rvalid_i))));
	assign advance = enable_i && !stall_o;

	assign load_data = done_q ? data_q : (cached ? req.rdata : mem_rdata_i[31:0]);

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			done_q <= 1'b0;
		end else if (advance) begin
			done_q <= 1'b0;
		end else if (acc_done) begin
			done_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (req.ready) begin
			data_q <= req.rdata;
		end else if (unc_rd_done) begin
			data_q <= mem_rdata_i[31:0];
		end
	end

	// register toward write-back
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			alu_o <= '0;
			mem_data_o <= '0;
			pc4_o <= '0;
			inst_o <= '0;
			wb_sel_o <= '0;
			reg_wen_o <= 1'b0;
			rd_o <= '0;
			csr_we_o <= 1'b0;
			csr_waddr_o <= '0;
			csr_rdata_o <= '0;
		end else if (advance && flush_i) begin
			alu_o <= '0;
			mem_data_o <= '0;
			pc4_o <= '0;
			inst_o <= '0;
			wb_sel_o <= '0;
			reg_wen_o <= 1'b0;
			rd_o <= '0;
			csr_we_o <= 1'b0;
			csr_waddr_o <= '0;
			csr_rdata_o <= '0;
		end else if (advance) begin
			alu_o <= alu_i;
			mem_data_o <= load_data;
			pc4_o <= pc4_i;
			inst_o <= inst_i;
			wb_sel_o <= wb_sel_i;
			reg_wen_o <= reg_wen_i;
			rd_o <= rd_i;
			csr_we_o <= csr_we_i;
			csr_waddr_o <= csr_waddr_i;
			csr_rdata_o <= csr_rdata_i;
		end
	end

endmodule

/* design/mem_subsys.sv */
`timescale 1ns/10ps

module mem_subsys (
	input logic clk_i,
	input logic rst_ni,
	input logic enable_i,
	input logic flush_i,
	input logic icache_stall_i,
	input logic access_i,
	input logic mem_rw_i,
	input dcache_pkg::word_t alu_i,
	input dcache_pkg::word_t rs2_i,
	input dcache_pkg::word_t pc4_i,
	input dcache_pkg::word_t inst_i,
	input dcache_pkg::wb_sel_t wb_sel_i,
	input logic reg_wen_i,
	input logic [4:0] rd_i,
	input logic csr_we_i,
	input dcache_pkg::word_t csr_waddr_i,
	input dcache_pkg::word_t csr_rdata_i,
	output dcache_pkg::word_t mem_addr_o,
	output dcache_pkg::line_t mem_wdata_o,
	output logic mem_we_o,
	output logic mem_cs_o,
	input dcache_pkg::line_t mem_rdata_i,
	input logic mem_rvalid_i,
	output logic stall_o,
	output dcache_pkg::word_t alu_o,
	output dcache_pkg::word_t mem_data_o,
	output dcache_pkg::word_t pc4_o,
	output dcache_pkg::word_t inst_o,
	output dcache_pkg::wb_sel_t wb_sel_o,
	output logic reg_wen_o,
	output logic [4:0] rd_o,
	output logic csr_we_o,
	output dcache_pkg::word_t csr_waddr_o,
	output dcache_pkg::word_t csr_rdata_o
);

	// line transfers between cache and stage
	logic bus_valid;
	logic bus_rw;
	dcache_pkg::word_t bus_addr;
	dcache_pkg::line_t bus_wdata;
	dcache_pkg::line_t bus_rdata;
	logic bus_rvalid;

	cache_req_if i_req_if ();

	mem_stage i_mem_stage (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.enable_i(enable_i),
		.flush_i(flush_i),
		.icache_stall_i(icache_stall_i),
		.access_i(access_i),
		.mem_rw_i(mem_rw_i),
		.alu_i(alu_i),
		.rs2_i(rs2_i),
		.pc4_i(pc4_i),
		.inst_i(inst_i),
		.wb_sel_i(wb_sel_i),
		.reg_wen_i(reg_wen_i),
		.rd_i(rd_i),
		.csr_we_i(csr_we_i),
		.csr_waddr_i(csr_waddr_i),
		.csr_rdata_i(csr_rdata_i),
		.req(i_req_if.cpu),
		.bus_valid_i(bus_valid),
		.bus_rw_i(bus_rw),
		.bus_addr_i(bus_addr),
		.bus_wdata_i(bus_wdata),
		.bus_rdata_o(bus_rdata),
		.bus_rvalid_o(bus_rvalid),
		.mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o),
		.mem_we_o(mem_we_o),
		.mem_cs_o(mem_cs_o),
		.mem_rdata_i(mem_rdata_i),
		.mem_rvalid_i(mem_rvalid_i),
		.stall_o(stall_o),
		.alu_o(alu_o),
		.mem_data_o(mem_data_o),
		.pc4_o(pc4_o),
		.inst_o(inst_o),
		.wb_sel_o(wb_sel_o),
		.reg_wen_o(reg_wen_o),
		.rd_o(rd_o),
		.csr_we_o(csr_we_o),
		.csr_waddr_o(csr_waddr_o),
		.csr_rdata_o(csr_rdata_o)
	);

	dcache i_dcache (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.req(i_req_if.cache),
		.bus_valid_o(bus_valid),
		.bus_rw_o(bus_rw),
		.bus_addr_o(bus_addr),
		.bus_wdata_o(bus_wdata),
		.bus_rdata_i(bus_rdata),
		.bus_rvalid_i(bus_rvalid)
	);

endmodule

/* sim.f */
+incdir+design
design/dcache_pkg.sv
design/cache_req_if.sv
design/dcache_array.sv
design/dcache.sv
design/mem_stage.sv
design/mem_subsys.sv
tb/mem_subsys_properties.sv
tb/tb_mem_subsys.sv

/* tb/mem_subsys_properties.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module mem_subsys_properties (
	input logic clk_i,
	input logic rst_ni,
	input logic enable_i,
	input logic flush_i,
	input logic icache_stall_i,
	input logic stall_o,
	input logic mem_cs_o,
	input logic mem_we_o,
	input logic mem_rvalid_i,
	input dcache_pkg::word_t mem_addr_o,
	input dcache_pkg::word_t alu_o,
	input dcache_pkg::word_t mem_data_o,
	input dcache_pkg::word_t pc4_o,
	input dcache_pkg::word_t inst_o,
	input logic reg_wen_o,
	input logic [4:0] rd_o,
	input logic csr_we_o
);

	// stage register holds while stalled or disabled
	hold_stage: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(stall_o || !enable_i) |=> $stable({alu_o, mem_data_o, pc4_o, inst_o, reg_wen_o,
		rd_o, csr_we_o}))
		else $error("stage register changed while held");

	flush_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(enable_i && !stall_o && flush_i) |=> (!reg_wen_o && !csr_we_o && alu_o == 0 &&
		mem_data_o == 0 && pc4_o == 0 && inst_o == 0))
		else $error("stage register not cleared by flush");

	icache_no_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
		icache_stall_i |-> !stall_o)
		else $error("stall raised during icache stall");

	icache_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(icache_stall_i && !mem_cs_o) |=> !(mem_cs_o && mem_addr_o[31:28] == `CACHED_NIBBLE))
		else $error("cache bus request during icache stall");

	// chip select and address held until acknowledge
	bus_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(mem_cs_o && !mem_rvalid_i && !(mem_we_o && mem_addr_o[31:28] != `CACHED_NIBBLE))
		|=> (mem_cs_o && $stable(mem_addr_o)))
		else $error("bus request dropped before acknowledge");

endmodule

bind mem_subsys mem_subsys_properties i_properties (.*);

/* tb/tb_mem_subsys.sv */
`timescale 1ns/10ps
`include "dcache_settings.svh"

module tb_mem_subsys;
	import dcache_pkg::*;

	logic clk_i, rst_ni, enable_i, flush_i, icache_stall_i, access_i, mem_rw_i;
	word_t alu_i, rs2_i, pc4_i, inst_i, csr_waddr_i, csr_rdata_i;
	wb_sel_t wb_sel_i;
	logic reg_wen_i, csr_we_i;
	logic [4:0] rd_i;
	word_t mem_addr_o, alu_o, mem_data_o, pc4_o, inst_o, csr_waddr_o, csr_rdata_o;
	line_t mem_wdata_o, mem_rdata_i, rdata_q;
	logic mem_we_o, mem_cs_o, mem_rvalid_i, stall_o, reg_wen_o, csr_we_o, ack_q;
	wb_sel_t wb_sel_o;
	logic [4:0] rd_o;

	word_t rand_state = 32'hc4f9_5168;
	line_t mem_lines [256];
	word_t shadow [1024];
	word_t exp_data, exp_addr, exp_wdata;
	int wait_cnt, dev_wr_cnt, wb_cnt, cycle_cnt;

	mem_subsys i_mem_subsys (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	function automatic word_t next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// initial memory contents, a function of the full address
	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h9e37_79b9) ^ 32'h1357_2468;
	endfunction

	// value returned by a device register
	function automatic word_t dev_word(input word_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'ha5c3_1e69;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	// memory model decides on the rising edge, drives on the falling edge
	task automatic serve_bus();
		int base;
		base = int'(mem_addr_o[11:4]);
		if (mem_addr_o[31:28] != `CACHED_NIBBLE) begin
			rdata_q = {next_rand(), next_rand(), next_rand(), dev_word(mem_addr_o)};
		end else if (mem_we_o) begin
			// evicted line must carry every store made to it
			for (int k = 0; k < 4; k++) begin
				check_value("mem_wdata_o", mem_wdata_o[32*k +: 32], shadow[base*4 + k]);
			end
			mem_lines[base] = mem_wdata_o;
			wb_cnt++;
		end else begin
			rdata_q = mem_lines[base];
		end
	endtask

	always @(posedge clk_i) begin
		word_t r;
		if (ack_q) begin
			ack_q = 1'b0;
		end else if (rst_ni && mem_cs_o &&
			!(mem_we_o && mem_addr_o[31:28] != `CACHED_NIBBLE)) begin
			if (wait_cnt == 0) begin
				r = next_rand();
				wait_cnt = 1 + int'(r[1:0]);
			end
			wait_cnt = wait_cnt - 1;
			if (wait_cnt == 0) begin
				serve_bus();
				ack_q = 1'b1;
			end
		end
		if (mem_cs_o && mem_we_o && mem_addr_o[31:28] != `CACHED_NIBBLE) begin
			check_value("mem_addr_o", mem_addr_o, exp_addr);
			check_value("mem_wdata_o", mem_wdata_o[31:0], exp_wdata);
			dev_wr_cnt++;
		end
	end

	always @(negedge clk_i) begin
		mem_rvalid_i = ack_q;
		mem_rdata_i = rdata_q;
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= 4000) begin
			$display("timeout: the run did not finish within 4000 cycles");
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic drive_access(input logic rw, input word_t addr, input word_t data);
		word_t r;
		r = next_rand();
		exp_data = (addr[31:28] == `CACHED_NIBBLE) ? shadow[addr[11:2]] : dev_word(addr);
		if (rw && addr[31:28] == `CACHED_NIBBLE) begin
			shadow[addr[11:2]] = data;
		end
		exp_addr = addr;
		exp_wdata = data;
		dev_wr_cnt = 0;
		access_i = 1'b1;
		mem_rw_i = rw;
		alu_i = addr;
		rs2_i = data;
		pc4_i = next_rand();
		inst_i = next_rand();
		rd_i = r[4:0];
		wb_sel_i = r[6:5];
		reg_wen_i = !rw;
		csr_we_i = r[7];
		csr_waddr_i = next_rand();
		csr_rdata_i = next_rand();
	endtask

	// wait for the stage register to load, then check it
	task automatic finish_access();
		do @(posedge clk_i); while (stall_o || !enable_i);
		@(negedge clk_i);
		access_i = 1'b0;
		check_value("alu_o", alu_o, alu_i);
		check_value("inst_o", inst_o, inst_i);
		check_value("pc4_o", pc4_o, pc4_i);
		check_value("wb_sel_o", 32'(wb_sel_o), 32'(wb_sel_i));
		check_value("rd_o", 32'(rd_o), 32'(rd_i));
		check_value("reg_wen_o", 32'(reg_wen_o), 32'(!mem_rw_i));
		check_value("csr_we_o", 32'(csr_we_o), 32'(csr_we_i));
		check_value("csr_waddr_o", csr_waddr_o, csr_waddr_i);
		check_value("csr_rdata_o", csr_rdata_o, csr_rdata_i);
		if (!mem_rw_i) begin
			check_value("mem_data_o", mem_data_o, exp_data);
		end else if (alu_i[31:28] != `CACHED_NIBBLE) begin
			check_value("uncached write cycles", dev_wr_cnt, 1);
		end
	endtask

	initial begin
		word_t r, a;
		int wb_before;
		{rst_ni, enable_i, flush_i, icache_stall_i, access_i, mem_rw_i} = '0;
		{alu_i, rs2_i, pc4_i, inst_i, csr_waddr_i, csr_rdata_i} = '0;
		{wb_sel_i, reg_wen_i, csr_we_i, rd_i} = '0;
		{mem_rdata_i, rdata_q, mem_rvalid_i, ack_q} = '0;
		{wait_cnt, dev_wr_cnt, wb_cnt, cycle_cnt} = '0;
		for (int w = 0; w < 1024; w++) begin
			shadow[w] = fill_word(32'(w * 4));
			mem_lines[w / 4][32*(w % 4) +: 32] = shadow[w];
		end
		repeat (10) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		check_value("mem_cs_o", 32'(mem_cs_o), 0);
		check_value("stall_o", 32'(stall_o), 0);
		check_value("reg_wen_o", 32'(reg_wen_o), 0);
		check_value("csr_we_o", 32'(csr_we_o), 0);
		enable_i = 1'b1;
		for (int n = 0; n < 200; n++) begin
			r = next_rand();
			a = {20'h0, r[11:10], 3'b000, r[6:4], r[3:2], 2'b00};
			case (r[14:12])
				3'd4: drive_access(1'b0, {4'h9, r[27:2], 2'b00}, next_rand());
				3'd5: drive_access(1'b1, {4'h9, r[27:2], 2'b00}, next_rand());
				3'd6: begin
					// dirty line evicted by a conflicting load
					drive_access(1'b1, a, next_rand());
					finish_access();
					wb_before = wb_cnt;
					drive_access(1'b0, a ^ 32'h400, 32'h0);
				end
				3'd7: begin
					// pipeline hold, then the cache is blocked by the icache stall
					drive_access(1'b0, a, 32'h0);
					enable_i = 1'b0;
					icache_stall_i = 1'b1;
					repeat (3) begin
						@(posedge clk_i);
						assert (!stall_o && !mem_cs_o) else begin
							stop_run("cache request started during an icache stall");
						end
					end
					@(negedge clk_i);
					icache_stall_i = 1'b0;
					// load finishes while the pipeline is still held
					do @(posedge clk_i); while (stall_o);
					@(negedge clk_i);
					enable_i = 1'b1;
				end
				default: drive_access(r[8], a, next_rand());
			endcase
			finish_access();
			if (r[14:12] == 3'd6) begin
				assert (wb_cnt == wb_before + 1) else begin
					stop_run("dirty line was not written back before the refill");
				end
			end
		end
		// flush clears the stage register
		flush_i = 1'b1;
		reg_wen_i = 1'b1;
		csr_we_i = 1'b1;
		@(posedge clk_i);
		@(negedge clk_i);
		flush_i = 1'b0;
		check_value("reg_wen_o", 32'(reg_wen_o), 0);
		check_value("csr_we_o", 32'(csr_we_o), 0);
		check_value("alu_o", alu_o, 0);
		check_value("mem_data_o", mem_data_o, 0);
		check_value("pc4_o", pc4_o, 0);
		check_value("inst_o", inst_o, 0);
		check_value("wb_sel_o", 32'(wb_sel_o), 0);
		check_value("rd_o", 32'(rd_o), 0);
		check_value("csr_waddr_o", csr_waddr_o, 0);
		check_value("csr_rdata_o", csr_rdata_o, 0);
		$display("TESTS PASSED");
		$finish;
	end

endmodule
